// File: all.f
source/ntm_arith_pkg.sv
source/ntm_ctrl_pkg.sv
source/ntm_config_regs.sv
source/ntm_scalar_inverter.sv
source/ntm_matrix_inverter.sv
source/ntm_inverter_top.sv
verif/ntm_inverter_sva.sv
verif/ntm_inverter_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module ntm_inverter_tb -f all.f -o ntm_sim > build.log 2>&1 \
  && ./obj_dir/ntm_sim > sim.log 2>&1 \
  || { cat build.log; echo "Test failed" >> sim.log; }

cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; } || echo "Simulation PASSED"

// File: verif/ntm_inverter_tb.sv
`default_nettype none
`timescale 1ns/100ps

module ntm_inverter_tb;

  import ntm_arith_pkg::*;
  import ntm_ctrl_pkg::*;

  // Cycles allowed for any single wait
  localparam int WAIT_LIMIT = 400;

  logic      CLK;
  logic      RST;
  logic      cfg_req_valid;
  cfg_req_t  cfg_req;
  logic      cfg_ack;
  logic      start;
  logic      busy;
  logic      elem_valid;
  elem_in_t  elem_in;
  logic      elem_ready;
  logic      out_valid;
  elem_out_t elem_out;

  int        seed = 32'h4d954927;
  int        errors;
  int        checks;
  int        tests;
  elem_out_t out_q[$];   // Results of the current run
  word_t     no_val[$];
  bit        no_has[$];

  ntm_inverter_top #(
    .DIM_SIZE (16)
  ) DUT (
    .CLK           (CLK),
    .RST           (RST),
    .cfg_req_valid (cfg_req_valid),
    .cfg_req       (cfg_req),
    .cfg_ack       (cfg_ack),
    .start         (start),
    .busy          (busy),
    .elem_valid    (elem_valid),
    .elem_in       (elem_in),
    .elem_ready    (elem_ready),
    .out_valid     (out_valid),
    .elem_out      (elem_out)
  );

  //////////////////////////////////////////////////////////////////////
  // Clock, output capture, reference model
  //////////////////////////////////////////////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Mid-cycle, outputs settled
  always @(negedge CLK) begin
    if (!RST && out_valid) out_q.push_back(elem_out);
  end

  // Integer extended Euclid
  function automatic inv_res_t ref_inverse(input word_t a, input word_t m);
    longint   r0, r1, s0, s1, q, t;
    inv_res_t res;
    r0 = longint'(a);
    r1 = longint'(m);
    s0 = 1;
    s1 = 0;
    while (r1 != 0) begin
      q  = r0 / r1;
      t  = r0 - q * r1;
      r0 = r1;
      r1 = t;
      t  = s0 - q * s1;
      s0 = s1;
      s1 = t;
    end
    res.has_inverse = (r0 == 1);
    // Fold a negative coefficient into [0, m)
    res.value = res.has_inverse ? word_t'(((s0 % longint'(m)) + longint'(m)) % longint'(m)) : '0;
    return res;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare and bookkeeping
  //////////////////////////////////////////////////////////////////////

  task automatic compare_elem(input string name, input elem_out_t exp, input elem_out_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %h inv=%b row=%b end=%b actual %h inv=%b row=%b end=%b",
               name, exp.value, exp.has_inverse, exp.row_end, exp.matrix_end,
               act.value, act.has_inverse, act.row_end, act.matrix_end);
    end
  endtask

  task automatic compare_view(input string name, input cfg_view_t exp, input cfg_view_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected mod=%0d %0dx%0d actual mod=%0d %0dx%0d", name,
               exp.modulus, exp.dims.rows, exp.dims.cols,
               act.modulus, act.dims.rows, act.dims.cols);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timeout while waiting for %s", what);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    $display("%-14s finished, %0d errors", name, errors - err_before);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus drivers
  //////////////////////////////////////////////////////////////////////

  // Inputs move 2 ns after the edge
  task automatic step_in();
    @(posedge CLK);
    #2;
  endtask

  task automatic cfg_write(input cfg_addr_e addr, input cfg_data_u data);
    int t;
    cfg_req.addr  = addr;
    cfg_req.data  = data;
    cfg_req_valid = 1'b1;
    t = 0;
    do begin
      @(negedge CLK);
      t++;
    end while (!cfg_ack && t < WAIT_LIMIT);
    if (!cfg_ack) report_timeout("cfg_ack high");
    step_in();
    cfg_req_valid = 1'b0;
    t = 0;
    do begin
      @(negedge CLK);
      t++;
    end while (cfg_ack && t < WAIT_LIMIT);
    if (cfg_ack) report_timeout("cfg_ack low");
    step_in();
  endtask

  task automatic write_modulus(input word_t m);
    cfg_data_u d;
    d.modulus = m;
    cfg_write(ADDR_MODULUS, d);
  endtask

  task automatic write_dims(input int rows, input int cols);
    cfg_data_u d;
    d.dims.rows = rows[DIM_W_MAX-1:0];
    d.dims.cols = cols[DIM_W_MAX-1:0];
    cfg_write(ADDR_DIMS, d);
  endtask

  task automatic send_elem(input word_t v);
    int t;
    elem_in.value = v;
    elem_valid    = 1'b1;
    t = 0;
    do begin
      @(negedge CLK);
      t++;
    end while (!elem_ready && t < WAIT_LIMIT);
    if (!elem_ready) report_timeout("elem_ready");
    // Transfer happens on this edge
    step_in();
    elem_valid = 1'b0;
  endtask

  // One full matrix, optional gaps and a modulus write after element 0
  task automatic run_matrix(input word_t elems[$], input int gap_max,
                            input bit mid_write, input word_t mid_mod);
    int gaps;
    int t;
    out_q.delete();
    start = 1'b1;
    step_in();
    start = 1'b0;
    foreach (elems[i]) begin
      gaps = ($random(seed) & 32'h7fff_ffff) % (gap_max + 1);
      repeat (gaps) step_in();
      send_elem(elems[i]);
      if (mid_write && i == 0) write_modulus(mid_mod);
    end
    t = 0;
    do begin
      @(negedge CLK);
      t++;
    end while (busy && t < WAIT_LIMIT);
    if (busy) report_timeout("busy low after the last element");
    step_in();
  endtask

  // Known values win over the reference model when given
  task automatic check_results(input string name, input word_t elems[$], input word_t m,
                               input int cols, input word_t known_val[$], input bit known_has[$]);
    elem_out_t exp_e;
    inv_res_t  r;
    int        n;
    n = elems.size();
    if (out_q.size() != n) begin
      errors++;
      $display("%s produced %0d results instead of %0d", name, out_q.size(), n);
    end
    for (int i = 0; i < n && i < out_q.size(); i++) begin
      if (known_val.size() == n) begin
        r.value       = known_val[i];
        r.has_inverse = known_has[i];
      end else begin
        r = ref_inverse(elems[i], m);
      end
      exp_e.value       = r.value;
      exp_e.has_inverse = r.has_inverse;
      exp_e.row_end     = (i % cols == cols - 1);
      exp_e.matrix_end  = (i == n - 1);
      compare_elem($sformatf("%s[%0d]", name, i), exp_e, out_q[i]);
    end
  endtask

  task automatic pick_modulus(output word_t m);
    m    = $random(seed);
    m[0] = 1'b1;
    if (m < 3) m = 3;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_config_writes();
    int        e0;
    int        row_ends;
    int        first_end;
    word_t     elems[$];
    cfg_view_t exp_v;
    cfg_view_t act_v;
    e0 = errors;
    write_dims(2, 3);
    write_modulus(32'd11);
    // Element 2 first, its inverse reveals the modulus
    elems = {32'd2, 32'd3, 32'd4, 32'd5, 32'd10, 32'd0};
    run_matrix(elems, 0, 1'b0, '0);
    check_results("config_writes", elems, 32'd11, 3, no_val, no_has);
    exp_v     = '{modulus: 32'd11, dims: '{rows: 16'd2, cols: 16'd3}};
    act_v     = '0;
    row_ends  = 0;
    first_end = 0;
    foreach (out_q[i]) begin
      if (out_q[i].row_end) begin
        row_ends++;
        if (first_end == 0) first_end = i + 1;
      end
    end
    if (out_q.size() > 0) act_v.modulus = (out_q[0].value << 1) - 32'd1;
    act_v.dims.rows = row_ends[DIM_W_MAX-1:0];
    act_v.dims.cols = first_end[DIM_W_MAX-1:0];
    compare_view("config_view", exp_v, act_v);
    finish_test("config_writes", e0);
  endtask

  task automatic test_known_inverses();
    int    e0;
    word_t elems[$];
    word_t exp_val[$];
    bit    exp_has[$];
    e0 = errors;
    write_dims(1, 4);
    write_modulus(32'd7);
    elems   = {32'd1, 32'd2, 32'd3, 32'd6};
    exp_val = {32'd1, 32'd4, 32'd5, 32'd6};
    exp_has = {1'b1, 1'b1, 1'b1, 1'b1};
    run_matrix(elems, 0, 1'b0, '0);
    check_results("known_inv", elems, 32'd7, 4, exp_val, exp_has);
    finish_test("known_inverses", e0);
  endtask

  task automatic test_no_inverse();
    int    e0;
    word_t elems[$];
    word_t exp_val[$];
    bit    exp_has[$];
    e0 = errors;
    // Dimensions stay 1x4
    write_modulus(32'd15);
    elems   = {32'd0, 32'd5, 32'd6, 32'd7};
    exp_val = {32'd0, 32'd0, 32'd0, 32'd13};
    exp_has = {1'b0, 1'b0, 1'b0, 1'b1};
    run_matrix(elems, 0, 1'b0, '0);
    check_results("no_inverse", elems, 32'd15, 4, exp_val, exp_has);
    finish_test("no_inverse", e0);
  endtask

  task automatic test_random_matrix();
    int    e0;
    word_t m;
    word_t rnd;
    word_t elems[$];
    e0 = errors;
    pick_modulus(m);
    write_dims(3, 3);
    write_modulus(m);
    repeat (9) begin
      rnd = $random(seed);
      elems.push_back(rnd % m);
    end
    run_matrix(elems, 0, 1'b0, '0);
    check_results("random_3x3", elems, m, 3, no_val, no_has);
    finish_test("random_matrix", e0);
  endtask

  task automatic test_stalls_rerun();
    int    e0;
    word_t m1;
    word_t m2;
    word_t rnd;
    word_t elems[$];
    e0 = errors;
    pick_modulus(m1);
    pick_modulus(m2);
    write_dims(2, 3);
    write_modulus(m1);
    repeat (6) begin
      rnd = $random(seed);
      elems.push_back(rnd % m1);
    end
    // Run keeps m1 despite the write
    run_matrix(elems, 3, 1'b1, m2);
    check_results("stall_run", elems, m1, 3, no_val, no_has);
    elems.delete();
    repeat (6) begin
      rnd = $random(seed);
      elems.push_back(rnd % m2);
    end
    run_matrix(elems, 3, 1'b0, '0);
    check_results("rerun", elems, m2, 3, no_val, no_has);
    finish_test("stalls_rerun", e0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    errors        = 0;
    checks        = 0;
    tests         = 0;
    RST           = 1'b1;
    cfg_req_valid = 1'b0;
    cfg_req       = '0;
    start         = 1'b0;
    elem_valid    = 1'b0;
    elem_in       = '0;
    repeat (2) @(posedge CLK);
    #2;
    RST = 1'b0;
    step_in();
    test_config_writes();
    test_known_inverses();
    test_no_inverse();
    test_random_matrix();
    test_stalls_rerun();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/ntm_inverter_sva.sv
`default_nettype none
`timescale 1ns/100ps

module ntm_inverter_sva (
  input logic CLK,
  input logic RST,
  input logic cfg_req_valid,
  input logic cfg_ack,
  input logic busy,
  input logic elem_ready,
  input logic inv_start,
  input logic out_valid
);

  //////////////////////////////////////////////////////////////////////
  // Four-phase config port
  //////////////////////////////////////////////////////////////////////

  // Ack rises one cycle after req is seen high
  a_ack_rise: assert property (@(posedge CLK) disable iff (RST)
    (cfg_req_valid && !cfg_ack) |=> cfg_ack)
    else $error("cfg_ack did not rise one cycle after req");

  // Ack falls one cycle after req is seen low
  a_ack_fall: assert property (@(posedge CLK) disable iff (RST)
    (!cfg_req_valid && cfg_ack) |=> !cfg_ack)
    else $error("cfg_ack did not fall one cycle after req dropped");

  // No ack without a req
  a_ack_idle: assert property (@(posedge CLK) disable iff (RST)
    (!cfg_req_valid && !cfg_ack) |=> !cfg_ack)
    else $error("cfg_ack rose with no req");

  //////////////////////////////////////////////////////////////////////
  // Stream timing
  //////////////////////////////////////////////////////////////////////

  // Output is a single-cycle pulse
  a_out_pulse: assert property (@(posedge CLK) disable iff (RST)
    out_valid |=> !out_valid)
    else $error("out_valid held for more than one cycle");

  a_ready_busy: assert property (@(posedge CLK) !busy |-> !elem_ready)
    else $error("elem_ready high while not busy");

  // All quiet during reset
  a_reset_quiet: assert property (@(posedge CLK)
    RST |-> !(cfg_ack || elem_ready || out_valid || busy || inv_start))
    else $error("control outputs active during reset");

endmodule

bind ntm_inverter_top ntm_inverter_sva u_sva (
  .CLK           (CLK),
  .RST           (RST),
  .cfg_req_valid (cfg_req_valid),
  .cfg_ack       (cfg_ack),
  .busy          (busy),
  .elem_ready    (elem_ready),
  .inv_start     (inv_start),
  .out_valid     (out_valid)
);

`default_nettype wire

// File: source/ntm_inverter_top.sv
`default_nettype none
`timescale 1ns/100ps

module ntm_inverter_top #(
  parameter int DIM_SIZE = 16
) (
  input  logic                     CLK,
  input  logic                     RST,
  // Configuration port
  input  logic                     cfg_req_valid,
  input  ntm_ctrl_pkg::cfg_req_t   cfg_req,
  output logic                     cfg_ack,
  // Run control
  input  logic                     start,
  output logic                     busy,
  // Element stream
  input  logic                     elem_valid,
  input  ntm_arith_pkg::elem_in_t  elem_in,
  output logic                     elem_ready,
  output logic                     out_valid,
  output ntm_arith_pkg::elem_out_t elem_out
);

  import ntm_arith_pkg::*;
  import ntm_ctrl_pkg::*;

  // Register view steering the sequencer
  cfg_view_t cfg_view;

  // Sequencer to scalar inverter
  logic     inv_start;
  inv_req_t inv_req;
  logic     inv_done;
  inv_res_t inv_res;

  ///////////////////////////////////////////////////////////////////////
  // Register block beside the sequencer
  ///////////////////////////////////////////////////////////////////////

  ntm_config_regs u_config_regs (
    .CLK           (CLK),
    .RST           (RST),
    .cfg_req_valid (cfg_req_valid),
    .cfg_req       (cfg_req),
    .cfg_ack       (cfg_ack),
    .cfg_view      (cfg_view)
  );

  ntm_matrix_inverter #(
    .DIM_SIZE (DIM_SIZE)
  ) u_matrix_inverter (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .busy       (busy),
    .cfg_view   (cfg_view),
    .elem_valid (elem_valid),
    .elem_in    (elem_in),
    .elem_ready (elem_ready),
    .inv_start  (inv_start),
    .inv_req    (inv_req),
    .inv_done   (inv_done),
    .inv_res    (inv_res),
    .out_valid  (out_valid),
    .elem_out   (elem_out)
  );

  // Variable latency, done pulse closes each element
  ntm_scalar_inverter u_scalar_inverter (
    .CLK       (CLK),
    .RST       (RST),
    .inv_start (inv_start),
    .inv_req   (inv_req),
    .inv_done  (inv_done),
    .inv_res   (inv_res)
  );

endmodule

`default_nettype wire

// File: source/ntm_matrix_inverter.sv
`default_nettype none
`timescale 1ns/100ps

module ntm_matrix_inverter #(
  parameter int DIM_SIZE = 16
) (
  input  logic                      CLK,
  input  logic                      RST,
  // Control
  input  logic                      start,
  output logic                      busy,
  input  ntm_ctrl_pkg::cfg_view_t   cfg_view,
  // Element input
  input  logic                      elem_valid,
  input  ntm_arith_pkg::elem_in_t   elem_in,
  output logic                      elem_ready,
  // Scalar inverter
  output logic                      inv_start,
  output ntm_arith_pkg::inv_req_t   inv_req,
  input  logic                      inv_done,
  input  ntm_arith_pkg::inv_res_t   inv_res,
  // Result stream
  output logic                      out_valid,
  output ntm_arith_pkg::elem_out_t  elem_out
);

  import ntm_arith_pkg::*;

  ///////////////////////////////////////////////////////////////////////
  // Sequencer state
  ///////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    S_IDLE      = 2'd0,
    S_WAIT_ELEM = 2'd1,
    S_WAIT_INV  = 2'd2,
    S_EMIT      = 2'd3   // Last result on the output
  } seq_state_e;

  seq_state_e state;

  // Settings copied at start
  word_t               mod_q;
  logic [DIM_SIZE-1:0] rows_q;
  logic [DIM_SIZE-1:0] cols_q;

  // Position of the element in flight
  logic [DIM_SIZE-1:0] row_cnt;
  logic [DIM_SIZE-1:0] col_cnt;

  logic elem_take;
  logic last_col;
  logic last_row;

  assign busy       = (state != S_IDLE);
  assign elem_ready = (state == S_WAIT_ELEM);
  assign elem_take  = elem_valid && elem_ready;
  assign last_col   = (col_cnt == cols_q - 1'b1);
  assign last_row   = (row_cnt == rows_q - 1'b1);

  // Control
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= S_IDLE;
      inv_start <= 1'b0;
      out_valid <= 1'b0;
      row_cnt   <= '0;
      col_cnt   <= '0;
    end else begin
      inv_start <= 1'b0;
      out_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            row_cnt <= '0;
            col_cnt <= '0;
            state   <= S_WAIT_ELEM;
          end
        end
        S_WAIT_ELEM: begin
          if (elem_take) begin
            inv_start <= 1'b1;
            state     <= S_WAIT_INV;
          end
        end
        S_WAIT_INV: begin
          if (inv_done) begin
            out_valid <= 1'b1;
            // Step row-major, wrap the column
            if (last_col) begin
              col_cnt <= '0;
              row_cnt <= row_cnt + 1'b1;
            end else begin
              col_cnt <= col_cnt + 1'b1;
            end
            state <= (last_col && last_row) ? S_EMIT : S_WAIT_ELEM;
          end
        end
        S_EMIT: state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // Payload
  always_ff @(posedge CLK) begin
    if (start && (state == S_IDLE)) begin
      mod_q  <= cfg_view.modulus;
      rows_q <= cfg_view.dims.rows[DIM_SIZE-1:0];
      cols_q <= cfg_view.dims.cols[DIM_SIZE-1:0];
    end
    // Pair each element with the latched modulus
    if (elem_take) begin
      inv_req.operand <= elem_in.value;
      inv_req.modulus <= mod_q;
    end
    if (inv_done && (state == S_WAIT_INV)) begin
      elem_out.value       <= inv_res.value;
      elem_out.has_inverse <= inv_res.has_inverse;
      elem_out.row_end     <= last_col;
      elem_out.matrix_end  <= last_col && last_row;
    end
  end

endmodule

`default_nettype wire

// File: source/ntm_scalar_inverter.sv
`default_nettype none
`timescale 1ns/100ps

module ntm_scalar_inverter (
  input  logic                    CLK,
  input  logic                    RST,
  // Request
  input  logic                    inv_start,
  input  ntm_arith_pkg::inv_req_t inv_req,
  // Result
  output logic                    inv_done,
  output ntm_arith_pkg::inv_res_t inv_res
);

  import ntm_arith_pkg::*;

  ///////////////////////////////////////////////////////////////////////
  // Modular helpers, odd modulus only
  ///////////////////////////////////////////////////////////////////////

  // x/2 mod m, add m first when x is odd
  function automatic word_t mod_half(input word_t x, input word_t m);
    logic [WORD_W:0] s;
    s = x[0] ? ({1'b0, x} + {1'b0, m}) : {1'b0, x};
    return s[WORD_W:1];
  endfunction

  // (a-b) mod m for a, b below m
  function automatic word_t mod_sub(input word_t a, input word_t b, input word_t m);
    logic [WORD_W:0] d;
    if (a >= b) begin
      d = {1'b0, a} - {1'b0, b};
    end else begin
      d = {1'b0, a} + {1'b0, m} - {1'b0, b};
    end
    return d[WORD_W-1:0];
  endfunction

  ///////////////////////////////////////////////////////////////////////
  // State
  ///////////////////////////////////////////////////////////////////////

  typedef enum logic {
    S_IDLE,
    S_RUN
  } inv_state_e;

  inv_state_e state;

  // Invariants x1*a = u and x2*a = v, all mod m
  word_t u;
  word_t v;
  word_t x1;
  word_t x2;
  word_t m_q;

  // Loop ends once either value is zero
  logic  finished;
  word_t gcd;
  word_t coef;
  logic  gcd_one;

  assign finished = (u == '0) || (v == '0);
  // Surviving value is the gcd, its coefficient the inverse
  assign gcd      = (u == '0) ? v : u;
  assign coef     = (u == '0) ? x2 : x1;
  assign gcd_one  = (gcd == word_t'(1));

  // Control
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= S_IDLE;
      inv_done <= 1'b0;
    end else begin
      inv_done <= 1'b0;
      case (state)
        S_IDLE: if (inv_start) state <= S_RUN;
        S_RUN: begin
          if (finished) begin
            inv_done <= 1'b1;
            state    <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Datapath, one reduction step per cycle
  always_ff @(posedge CLK) begin
    if (state == S_IDLE) begin
      if (inv_start) begin
        u   <= inv_req.operand;
        v   <= inv_req.modulus;
        x1  <= word_t'(1);
        x2  <= '0;
        m_q <= inv_req.modulus;
      end
    end else if (finished) begin
      inv_res.has_inverse <= gcd_one;
      inv_res.value       <= gcd_one ? coef : '0;
    end else if (!u[0]) begin
      u  <= u >> 1;
      x1 <= mod_half(x1, m_q);
    end else if (!v[0]) begin
      v  <= v >> 1;
      x2 <= mod_half(x2, m_q);
    end else if (u >= v) begin
      // Odd minus odd is even, halve in the same step
      u  <= (u - v) >> 1;
      x1 <= mod_half(mod_sub(x1, x2, m_q), m_q);
    end else begin
      v  <= (v - u) >> 1;
      x2 <= mod_half(mod_sub(x2, x1, m_q), m_q);
    end
  end

endmodule

`default_nettype wire

// File: source/ntm_config_regs.sv
`default_nettype none
`timescale 1ns/100ps

module ntm_config_regs (
  input  logic                   CLK,
  input  logic                   RST,
  // Four-phase write port
  input  logic                   cfg_req_valid,
  input  ntm_ctrl_pkg::cfg_req_t cfg_req,
  output logic                   cfg_ack,
  // Settings to the sequencer
  output ntm_ctrl_pkg::cfg_view_t cfg_view
);

  import ntm_ctrl_pkg::*;

  ///////////////////////////////////////////////////////////////////////
  // Handshake engine
  ///////////////////////////////////////////////////////////////////////

  typedef enum logic {
    HS_IDLE,  // Waiting for req
    HS_ACK    // Ack held until req drops
  } hs_state_e;

  // Power-up settings, modulus 3 on a 1x1 matrix
  localparam cfg_view_t VIEW_RST = '{
    modulus: 32'd3,
    dims:    '{rows: 16'd1, cols: 16'd1}
  };

  hs_state_e hs_state;

  // Ack is the state itself, so it is always registered
  assign cfg_ack = (hs_state == HS_ACK);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      hs_state <= HS_IDLE;
      cfg_view <= VIEW_RST;
    end else begin
      case (hs_state)
        HS_IDLE: begin
          if (cfg_req_valid) begin
            // Same word, two readings
            case (cfg_req.addr)
              ADDR_MODULUS: cfg_view.modulus <= cfg_req.data.modulus;
              ADDR_DIMS:    cfg_view.dims    <= cfg_req.data.dims;
              default:      cfg_view         <= cfg_view;
            endcase
            hs_state <= HS_ACK;
          end
        end
        HS_ACK: begin
          // Release once req is seen low
          if (!cfg_req_valid) begin
            hs_state <= HS_IDLE;
          end
        end
        default: begin
          hs_state <= HS_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/ntm_ctrl_pkg.sv
`default_nettype none

package ntm_ctrl_pkg;

  import ntm_arith_pkg::*;

  // Width of each dimension field
  parameter int DIM_W_MAX = 16;

  // Register select
  typedef enum logic [0:0] {
    ADDR_MODULUS = 1'b0,
    ADDR_DIMS    = 1'b1
  } cfg_addr_e;

  // Matrix shape
  typedef struct packed {
    logic [DIM_W_MAX-1:0] rows;
    logic [DIM_W_MAX-1:0] cols;
  } dims_t;

  // Write word, meaning set by the address
  typedef union packed {
    word_t modulus;
    dims_t dims;
  } cfg_data_u;

  // One configuration write
  typedef struct packed {
    cfg_addr_e addr;
    cfg_data_u data;
  } cfg_req_t;

  // Register contents seen by the sequencer
  typedef struct packed {
    word_t modulus;
    dims_t dims;
  } cfg_view_t;

endpackage

`default_nettype wire

// File: source/ntm_arith_pkg.sv
`default_nettype none

package ntm_arith_pkg;

  ///////////////////////////////////////////////////////////////////////
  // Data word
  ///////////////////////////////////////////////////////////////////////

  // Width of every matrix element and of the modulus
  parameter int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;

  ///////////////////////////////////////////////////////////////////////
  // Element stream
  ///////////////////////////////////////////////////////////////////////

  // One matrix element, row-major order
  typedef struct packed {
    word_t value;
  } elem_in_t;

  // Inverse plus the stream markers
  typedef struct packed {
    word_t value;
    logic  has_inverse;  // Zero value when clear
    logic  row_end;      // Last column of a row
    logic  matrix_end;   // Last element of the matrix
  } elem_out_t;

  ///////////////////////////////////////////////////////////////////////
  // Scalar inverter link
  ///////////////////////////////////////////////////////////////////////

  // Operand and odd modulus
  typedef struct packed {
    word_t operand;
    word_t modulus;
  } inv_req_t;

  // Inverse, valid only with has_inverse
  typedef struct packed {
    word_t value;
    logic  has_inverse;
  } inv_res_t;

endpackage

`default_nettype wire
